// ==== common/bridge_settings.svh ====
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// Link and dbio widths
`define BYTE_W 8
`define ADDR_W 12
`define DATA_W 64
`define LEN_W 16
`define LANE_W 4

// Send FIFO holds 2**FIFO_DEPTH_LOG2 bytes
`define FIFO_DEPTH_LOG2 4

// Timeout in tick1k periods
`define TIMEOUT_MS 1000

// Protocol bytes
`define SYNC_BYTE 8'h55
`define ACK_BYTE 8'h00

`endif

// ==== common/ftdiPkg.sv ====
`default_nettype none
`include "bridge_settings.svh"

package ftdiPkg;

  typedef logic [`BYTE_W-1:0] linkByte_t;

  // Inputs from the FIFO chip
  typedef struct packed {
    linkByte_t dataIn;
    logic      rxFull;
    logic      txEmpty;
  } ftdiIn_t;

  typedef struct packed {
    linkByte_t dataOut;
    logic      dataOe;
    logic      rd;
    logic      wr;
  } ftdiOut_t;

endpackage

`default_nettype wire

// ==== common/dbioPkg.sv ====
`default_nettype none
`include "bridge_settings.svh"

package dbioPkg;

  typedef enum logic [3:0] {
    cmdRead  = 4'h8,
    cmdWrite = 4'hC
  } cmdCode_e;

  // Control word arrives as two bytes, decoded as code and address
  typedef union packed {
    struct packed {
      ftdiPkg::linkByte_t hi;
      ftdiPkg::linkByte_t lo;
    } bytes;
    struct packed {
      cmdCode_e                code;
      logic [`ADDR_W-1:0]      addr;
    } fields;
  } ctrlWord_u;

  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] mosi;
    logic [`LANE_W-1:0] mosiIdx;
    logic [`LANE_W-1:0] misoIdx;
    logic [`LEN_W-1:0]  dataLen;
    logic               dataLenNz;
    logic               mosi1st;
    logic               miso1st;
    logic               mosiStrobe;
  } dbioPort_t;

  typedef struct packed {
    logic               mosiStart;
    logic               mosiWrite;
    logic               misoLoad;
    logic               misoShift;
    ftdiPkg::linkByte_t rxByte;
    logic [`ADDR_W-1:0] addr;
    logic [`LEN_W-1:0]  dataLen;
    logic               dataLenNz;
    logic               miso1st;
  } bufCmd_t;

endpackage

`default_nettype wire

// ==== ftdi/ftdiLink.sv ====
`timescale 1ns/1ps
`default_nettype none

module ftdiLink (
  input  logic               clkH,
  input  logic               reset,
  input  ftdiPkg::ftdiIn_t   pins,
  output ftdiPkg::ftdiOut_t  pinsOut,
  output logic               rxValid,
  output ftdiPkg::linkByte_t rxByte,
  input  ftdiPkg::linkByte_t fifoHead,
  input  logic               fifoHasData,
  output logic               fifoPop
);

  localparam int RecvA = 0;
  localparam int RecvB = 1;
  localparam int SendA = 2;
  localparam int SendB = 3;

  logic [3:0] state;
  logic [3:0] stateNext;
  logic rxFullQ;
  logic txEmptyQ;
  logic idle;
  ftdiPkg::linkByte_t rxData;

  always_ff @(posedge clkH) begin
    if (reset) begin
      rxFullQ  <= 1'b0;
      txEmptyQ <= 1'b0;
      state    <= '0;
    end else begin
      rxFullQ  <= pins.rxFull;
      txEmptyQ <= pins.txEmpty;
      state    <= stateNext;
    end
  end

  // Byte is taken during the rd cycle
  always_ff @(posedge clkH) begin
    if (state[RecvA]) begin
      rxData <= pins.dataIn;
    end
  end

  assign idle = ~|state;

  // Receive wins over send
  always_comb begin
    stateNext        = '0;
    stateNext[RecvA] = idle & rxFullQ;
    stateNext[RecvB] = state[RecvA];
    stateNext[SendA] = idle & ~rxFullQ & fifoHasData & txEmptyQ;
    stateNext[SendB] = state[SendA];
  end

  assign rxValid = state[RecvB];
  assign rxByte  = rxData;
  assign fifoPop = state[SendB];

  always_comb begin
    pinsOut.dataOut = fifoHead;
    pinsOut.dataOe  = state[SendA] | state[SendB];
    pinsOut.rd      = state[RecvA];
    pinsOut.wr      = state[SendB];
  end

endmodule

`default_nettype wire

// ==== ftdi/sendFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sendFifo #(
  parameter int depthLog2 = 4
) (
  input  logic               clkH,
  input  logic               reset,
  input  logic               pushValid,
  input  ftdiPkg::linkByte_t pushByte,
  input  logic               pop,
  output ftdiPkg::linkByte_t head,
  output logic               hasData,
  output logic               hasSpace
);

  localparam int Depth = 1 << depthLog2;

  ftdiPkg::linkByte_t mem [Depth];
  logic [depthLog2-1:0] rdPtr;
  logic [depthLog2-1:0] wrPtr;
  logic [depthLog2:0]   count;
  logic doPush;
  logic doPop;

  assign doPush = pushValid & hasSpace;
  assign doPop  = pop & hasData;

  // Count never exceeds Depth, so the top bit means full
  assign hasData  = |count;
  assign hasSpace = ~count[depthLog2];
  assign head     = mem[rdPtr];

  always_ff @(posedge clkH) begin
    if (reset) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clkH) begin
    if (doPush) begin
      mem[wrPtr] <= pushByte;
    end
  end

endmodule

`default_nettype wire

// ==== logic/commandEngine.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_settings.svh"

module commandEngine (
  input  logic               clkH,
  input  logic               reset,
  input  logic               tick1k,
  input  logic               rxValid,
  input  ftdiPkg::linkByte_t rxByte,
  input  logic               hasSpace,
  output logic               pushValid,
  output ftdiPkg::linkByte_t pushByte,
  output dbioPkg::bufCmd_t   bufCmd,
  input  ftdiPkg::linkByte_t misoLow
);

  localparam int StSyncA    = 0;
  localparam int StSyncB    = 1;
  localparam int StHdrCtrl  = 2;
  localparam int StHdrLenLo = 3;
  localparam int StHdrLenHi = 4;
  localparam int StWrData   = 5;
  localparam int StWrAck    = 6;
  localparam int StRdStat   = 7;
  localparam int StRdData   = 8;
  localparam int StLen      = 9;

  localparam int ToW  = $clog2(`TIMEOUT_MS + 1);
  localparam int LenW = `LEN_W;

  logic [StLen-1:0] state;
  logic [StLen-1:0] stateNext;
  logic [ToW-1:0]   timeout;
  logic [LenW-1:0]  len;
  logic [LenW-1:0]  newLen;
  dbioPkg::ctrlWord_u ctrl;
  logic idle;
  logic toNz;
  logic lenNz;
  logic lenLast;
  logic newLenNz;
  logic hdrDone;
  logic isWrite;
  logic isRead;
  logic lenDec;

  assign idle     = ~|state;
  assign toNz     = |timeout;
  assign lenNz    = |len;
  assign lenLast  = len == LenW'(1);
  assign newLen   = {rxByte, len[`BYTE_W-1:0]};
  assign newLenNz = |newLen;
  assign hdrDone  = state[StHdrLenHi] & rxValid;
  assign isWrite  = ctrl.fields.code == dbioPkg::cmdWrite;
  assign isRead   = ctrl.fields.code == dbioPkg::cmdRead;

  // Unknown codes fall out of the header to idle
  always_comb begin
    stateNext             = '0;
    stateNext[StSyncA]    = idle & rxValid & (rxByte == `SYNC_BYTE);
    stateNext[StSyncB]    = state[StSyncA] | (state[StSyncB] & ~hasSpace);
    stateNext[StHdrCtrl]  = (idle & rxValid & rxByte[`BYTE_W-1]) |
                            (state[StHdrCtrl] & ~rxValid & toNz);
    stateNext[StHdrLenLo] = (state[StHdrCtrl] & rxValid) |
                            (state[StHdrLenLo] & ~rxValid & toNz);
    stateNext[StHdrLenHi] = (state[StHdrLenLo] & rxValid) |
                            (state[StHdrLenHi] & ~rxValid & toNz);
    stateNext[StWrData]   = (hdrDone & isWrite & newLenNz) |
                            (state[StWrData] & rxValid & ~lenLast) |
                            (state[StWrData] & ~rxValid & toNz);
    stateNext[StWrAck]    = (hdrDone & isWrite & ~newLenNz) |
                            (state[StWrData] & rxValid & lenLast) |
                            (state[StWrAck] & ~hasSpace);
    stateNext[StRdStat]   = (hdrDone & isRead) | (state[StRdStat] & ~hasSpace);
    stateNext[StRdData]   = (state[StRdStat] & hasSpace) | (state[StRdData] & lenNz);
  end

  assign lenDec = bufCmd.mosiWrite | bufCmd.misoShift;

  always_ff @(posedge clkH) begin
    if (reset) begin
      state   <= '0;
      timeout <= '0;
      len     <= '0;
    end else begin
      state <= stateNext;
      if (rxValid) begin
        timeout <= ToW'(`TIMEOUT_MS);
      end else if (tick1k & toNz) begin
        timeout <= timeout - 1'b1;
      end
      if (state[StHdrLenLo] & rxValid) begin
        len <= LenW'(rxByte);
      end else if (hdrDone) begin
        len <= newLen;
      end else if (lenDec) begin
        len <= len - LenW'(1);
      end
    end
  end

  // Control word, high byte first
  always_ff @(posedge clkH) begin
    if (idle & rxValid) begin
      ctrl.bytes.hi <= rxByte;
    end
    if (state[StHdrCtrl] & rxValid) begin
      ctrl.bytes.lo <= rxByte;
    end
  end

  always_comb begin
    pushValid = hasSpace & (state[StSyncB] | state[StWrAck] | state[StRdStat] |
                            (state[StRdData] & lenNz));
    if (state[StSyncB]) begin
      pushByte = `SYNC_BYTE;
    end else if (state[StRdData]) begin
      pushByte = misoLow;
    end else begin
      pushByte = `ACK_BYTE;
    end
  end

  always_comb begin
    bufCmd.mosiStart = hdrDone & isWrite;
    bufCmd.mosiWrite = state[StWrData] & rxValid;
    bufCmd.misoLoad  = hdrDone & isRead;
    bufCmd.misoShift = state[StRdData] & lenNz & hasSpace;
    bufCmd.rxByte    = rxByte;
    bufCmd.addr      = ctrl.fields.addr;
    bufCmd.dataLen   = newLen;
    bufCmd.dataLenNz = lenNz;
    bufCmd.miso1st   = state[StRdStat];
  end

endmodule

`default_nettype wire

// ==== logic/dbioBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_settings.svh"

module dbioBuffer (
  input  logic                clkH,
  input  logic                reset,
  input  dbioPkg::bufCmd_t    bufCmd,
  input  logic [`DATA_W-1:0]  dbioMiso,
  output ftdiPkg::linkByte_t  misoLow,
  output dbioPkg::dbioPort_t  dbio
);

  logic [`ADDR_W-1:0] addr;
  logic [`LEN_W-1:0]  dataLen;
  logic [`DATA_W-1:0] mosi;
  logic [`DATA_W-1:0] miso;
  logic [`LANE_W-1:0] mosiIdx;
  logic [`LANE_W-1:0] misoIdx;
  logic mosi1st;
  logic mosiStrobe;

  always_ff @(posedge clkH) begin
    if (reset) begin
      mosiIdx    <= '0;
      misoIdx    <= '0;
      mosi1st    <= 1'b0;
      mosiStrobe <= 1'b0;
    end else begin
      mosi1st    <= bufCmd.mosiStart;
      mosiStrobe <= bufCmd.mosiWrite;
      if (bufCmd.mosiStart) begin
        mosiIdx <= '0;
      end else if (bufCmd.mosiWrite) begin
        mosiIdx <= mosiIdx + 1'b1;
      end
      if (bufCmd.misoLoad) begin
        misoIdx <= '0;
      end else if (bufCmd.misoShift) begin
        misoIdx <= misoIdx + 1'b1;
      end
    end
  end

  always_ff @(posedge clkH) begin
    if (bufCmd.mosiStart | bufCmd.misoLoad) begin
      addr    <= bufCmd.addr;
      dataLen <= bufCmd.dataLen;
    end
    // Lane index wraps after 8 bytes
    if (bufCmd.mosiWrite) begin
      mosi[mosiIdx[2:0]*`BYTE_W +: `BYTE_W] <= bufCmd.rxByte;
    end
    if (bufCmd.misoLoad) begin
      miso <= dbioMiso;
    end else if (bufCmd.misoShift) begin
      miso <= miso >> `BYTE_W;
    end
  end

  assign misoLow = miso[`BYTE_W-1:0];

  always_comb begin
    dbio.addr       = addr;
    dbio.mosi       = mosi;
    dbio.mosiIdx    = mosiIdx;
    dbio.misoIdx    = misoIdx;
    dbio.dataLen    = dataLen;
    dbio.dataLenNz  = bufCmd.dataLenNz;
    dbio.mosi1st    = mosi1st;
    dbio.miso1st    = bufCmd.miso1st;
    dbio.mosiStrobe = mosiStrobe;
  end

endmodule

`default_nettype wire

// ==== logic/testBridgeFtdi.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_settings.svh"

module testBridgeFtdi (
  input  logic               clkH,
  input  logic               reset,
  input  logic               tick1k,
  input  ftdiPkg::ftdiIn_t   pins,
  output ftdiPkg::ftdiOut_t  pinsOut,
  input  logic [`DATA_W-1:0] dbioMiso,
  output dbioPkg::dbioPort_t dbio
);

  logic               rxValid;
  ftdiPkg::linkByte_t rxByte;
  logic               pushValid;
  ftdiPkg::linkByte_t pushByte;
  logic               fifoPop;
  ftdiPkg::linkByte_t fifoHead;
  logic               fifoHasData;
  logic               fifoHasSpace;
  ftdiPkg::linkByte_t misoLow;
  dbioPkg::bufCmd_t   bufCmd;

  ftdiLink i_ftdiLink (
    .clkH        (clkH),
    .reset       (reset),
    .pins        (pins),
    .pinsOut     (pinsOut),
    .rxValid     (rxValid),
    .rxByte      (rxByte),
    .fifoHead    (fifoHead),
    .fifoHasData (fifoHasData),
    .fifoPop     (fifoPop)
  );

  sendFifo #(
    .depthLog2 (`FIFO_DEPTH_LOG2)
  ) i_sendFifo (
    .clkH      (clkH),
    .reset     (reset),
    .pushValid (pushValid),
    .pushByte  (pushByte),
    .pop       (fifoPop),
    .head      (fifoHead),
    .hasData   (fifoHasData),
    .hasSpace  (fifoHasSpace)
  );

  commandEngine i_commandEngine (
    .clkH      (clkH),
    .reset     (reset),
    .tick1k    (tick1k),
    .rxValid   (rxValid),
    .rxByte    (rxByte),
    .hasSpace  (fifoHasSpace),
    .pushValid (pushValid),
    .pushByte  (pushByte),
    .bufCmd    (bufCmd),
    .misoLow   (misoLow)
  );

  dbioBuffer i_dbioBuffer (
    .clkH     (clkH),
    .reset    (reset),
    .bufCmd   (bufCmd),
    .dbioMiso (dbioMiso),
    .misoLow  (misoLow),
    .dbio     (dbio)
  );

endmodule

`default_nettype wire

// ==== tb/testBridgeFtdi_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module testBridgeFtdi_checker (
  input logic clkH,
  input logic reset,
  input logic rd,
  input logic wr,
  input logic dataOe,
  input logic txEmptyQ
);

  int failCount = 0;

  rdWrExclusive: assert property (@(posedge clkH) disable iff (reset) !(rd && wr))
    else begin
      $error("rd and wr are high in the same cycle");
      failCount++;
    end

  // Bus is driven one cycle ahead of wr
  wrDrivesBus: assert property (@(posedge clkH) disable iff (reset)
                                wr |-> dataOe && $past(dataOe))
    else begin
      $error("wr is high without the data bus driven since the cycle before");
      failCount++;
    end

  // Send cycle starts only on a high registered txEmpty
  // wr follows one cycle later
  wrNeedsRoom: assert property (@(posedge clkH) disable iff (reset) wr |-> $past(txEmptyQ, 2))
    else begin
      $error("wr follows a low registered txEmpty");
      failCount++;
    end

  rdOneCycle: assert property (@(posedge clkH) disable iff (reset) rd |=> !rd)
    else begin
      $error("rd is high for more than one cycle");
      failCount++;
    end

endmodule

bind ftdiLink testBridgeFtdi_checker i_checker (
  .clkH     (clkH),
  .reset    (reset),
  .rd       (pinsOut.rd),
  .wr       (pinsOut.wr),
  .dataOe   (pinsOut.dataOe),
  .txEmptyQ (txEmptyQ)
);

`default_nettype wire

// ==== tb/testBridgeFtdi_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bridge_settings.svh"

module testBridgeFtdi_tb;

  localparam int NumTests   = 6;
  localparam int TestBudget = 200_000;
  localparam int KindSync   = 0;
  localparam int KindWrite  = 1;
  localparam int KindRead   = 2;

  logic clkH;
  logic reset;
  logic tick1k;
  logic [7:0] hostData;
  logic hostRxFull;
  logic hostTxEmpty;
  logic [`DATA_W-1:0] dbioMiso;
  ftdiPkg::ftdiIn_t pins;
  ftdiPkg::ftdiOut_t pinsOut;
  dbioPkg::dbioPort_t dbio;

  int seed = 89;
  int txMode = 0;
  int txPhase = 0;
  int lowRun = 0;
  int valueErrs = 0;
  int otherErrs = 0;
  int checkerErrs;
  int strobeCnt = 0;
  int mosiFirstCnt = 0;
  int misoFirstCnt = 0;
  logic [7:0] gotByte;
  logic [7:0] expQ [$];
  logic [7:0] gotQ [$];

  assign pins = {hostData, hostRxFull, hostTxEmpty};

  testBridgeFtdi i_testBridgeFtdi (
    .clkH     (clkH),
    .reset    (reset),
    .tick1k   (tick1k),
    .pins     (pins),
    .pinsOut  (pinsOut),
    .dbioMiso (dbioMiso),
    .dbio     (dbio)
  );

  initial begin
    clkH = 1'b0;
    forever #10 clkH = ~clkH;
  end

  // txMode 0 keeps room, 1 is random, 2 gives long low stretches
  initial begin
    hostTxEmpty = 1'b1;
    forever begin
      @(negedge clkH);
      txPhase++;
      if (txMode == 1) begin
        hostTxEmpty = ($unsigned($random(seed)) % 4) != 0;
      end else if (txMode == 2) begin
        hostTxEmpty = (txPhase % 40) >= 34;
      end else begin
        hostTxEmpty = 1'b1;
      end
    end
  end

  always @(posedge clkH) begin
    lowRun <= hostTxEmpty ? 0 : lowRun + 1;
  end

  // Host side of the chip takes each written byte
  always @(negedge clkH) begin
    if (pinsOut.wr) begin
      gotQ.push_back(pinsOut.dataOut);
      assert (lowRun <= 2) else begin
        $display("%0t wr pulsed although the chip had no room for a while", $time);
        otherErrs++;
      end
    end
  end

  // Marker pulses seen on the dbio port
  always @(negedge clkH) begin
    if (dbio.mosiStrobe) begin
      strobeCnt++;
    end
    if (dbio.mosi1st) begin
      mosiFirstCnt++;
    end
    if (dbio.miso1st) begin
      misoFirstCnt++;
    end
  end

  always @(posedge clkH) begin
    if (gotQ.size() != 0) begin
      gotByte = gotQ.pop_front();
      assert (expQ.size() != 0) else begin
        $display("%0t bridge sent byte %h that no command asked for", $time, gotByte);
        otherErrs++;
      end
      if (expQ.size() != 0) begin
        checkValue("pinsOut.dataOut", expQ.pop_front(), gotByte);
      end
    end
  end

  initial begin
    #(NumTests * TestBudget);
    $display("Watchdog expired at %0t before the tests finished", $time);
    $display("Test failed");
    $finish;
  end

  task automatic checkValue(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got == exp) else begin
      $display("ERR %0t %s exp %0h got %0h", $time, name, exp, got);
      valueErrs++;
    end
  endtask

  function automatic logic [7:0] refReply(input int kind, input int idx,
                                          input logic [`DATA_W-1:0] miso);
    logic [7:0] b;
    if (kind == KindSync) begin
      b = `SYNC_BYTE;
    end else if (kind == KindRead && idx > 0) begin
      b = miso[(idx-1)*8 +: 8];
    end else begin
      b = `ACK_BYTE;
    end
    return b;
  endfunction

  function automatic logic [`DATA_W-1:0] refMosi(input logic [7:0] data [8], input int len);
    logic [`DATA_W-1:0] w;
    w = '0;
    for (int k = 0; k < len; k++) begin
      w[k*8 +: 8] = data[k];
    end
    return w;
  endfunction

  task automatic sendByte(input logic [7:0] b);
    @(negedge clkH);
    hostData   = b;
    hostRxFull = 1'b1;
    @(negedge clkH);
    while (!pinsOut.rd) begin
      @(negedge clkH);
    end
    hostRxFull = 1'b0;
  endtask

  // Control word high byte first, length low byte first
  task automatic sendHeader(input logic [3:0] code, input logic [11:0] addr,
                            input logic [15:0] len);
    sendByte({code, addr[11:8]});
    sendByte(addr[7:0]);
    sendByte(len[7:0]);
    sendByte(len[15:8]);
  endtask

  task automatic waitReplies();
    while (expQ.size() != 0 || gotQ.size() != 0) begin
      @(negedge clkH);
    end
    repeat (30) @(negedge clkH);
  endtask

  task automatic runReset();
    repeat (3) @(posedge clkH);
    @(negedge clkH);
    reset = 1'b0;
    repeat (20) begin
      @(negedge clkH);
      checkValue("pinsOut.rd", 0, pinsOut.rd);
      checkValue("pinsOut.wr", 0, pinsOut.wr);
      checkValue("pinsOut.dataOe", 0, pinsOut.dataOe);
      checkValue("dbio.mosiStrobe", 0, dbio.mosiStrobe);
      checkValue("dbio.mosi1st", 0, dbio.mosi1st);
      checkValue("dbio.miso1st", 0, dbio.miso1st);
    end
  endtask

  task automatic runSync();
    expQ.push_back(refReply(KindSync, 0, '0));
    sendByte(`SYNC_BYTE);
    waitReplies();
  endtask

  task automatic runWrite();
    logic [11:0] addr;
    int len;
    logic [7:0] data [8];
    logic [`DATA_W-1:0] expMosi;
    addr = 12'($random(seed));
    len  = 1 + ($unsigned($random(seed)) % 8);
    for (int k = 0; k < 8; k++) begin
      data[k] = 8'($random(seed));
    end
    expMosi = refMosi(data, len);
    expQ.push_back(refReply(KindWrite, 0, '0));
    strobeCnt    = 0;
    mosiFirstCnt = 0;
    sendHeader(dbioPkg::cmdWrite, addr, 16'(len));
    for (int k = 0; k < len; k++) begin
      sendByte(data[k]);
    end
    waitReplies();
    checkValue("dbio.addr", addr, dbio.addr);
    checkValue("dbio.dataLen", len, dbio.dataLen);
    checkValue("dbio.mosiIdx", len, dbio.mosiIdx);
    checkValue("dbio.dataLenNz", 0, dbio.dataLenNz);
    checkValue("dbio.mosiStrobe pulses", len, strobeCnt);
    checkValue("dbio.mosi1st pulses", 1, mosiFirstCnt);
    for (int k = 0; k < len; k++) begin
      checkValue($sformatf("dbio.mosi lane %0d", k), expMosi[k*8 +: 8], dbio.mosi[k*8 +: 8]);
    end
  endtask

  task automatic runRead(input int len);
    dbioMiso = {$random(seed), $random(seed)};
    for (int k = 0; k <= len; k++) begin
      expQ.push_back(refReply(KindRead, k, dbioMiso));
    end
    misoFirstCnt = 0;
    sendHeader(dbioPkg::cmdRead, 12'($random(seed)), 16'(len));
    waitReplies();
    checkValue("dbio.dataLen", len, dbio.dataLen);
    checkValue("dbio.misoIdx", len, dbio.misoIdx);
    checkValue("dbio.miso1st cycles", 1, misoFirstCnt);
  endtask

  task automatic runTimeout();
    sendByte({dbioPkg::cmdWrite, 4'h3});
    sendByte(8'h21);
    repeat (`TIMEOUT_MS + 10) begin
      @(negedge clkH);
      tick1k = 1'b1;
      @(negedge clkH);
      tick1k = 1'b0;
    end
    runSync();
  endtask

  initial begin
    reset      = 1'b1;
    tick1k     = 1'b0;
    hostData   = '0;
    hostRxFull = 1'b0;
    dbioMiso   = '0;
    runReset();
    txMode = 1;
    runSync();
    runWrite();
    runRead(1 + ($unsigned($random(seed)) % 8));
    runTimeout();
    txMode = 2;
    runRead(8);
    txMode = 0;
    checkerErrs = i_testBridgeFtdi.i_ftdiLink.i_checker.failCount;
    $display("Errors: %0d value, %0d other, %0d pin protocol",
             valueErrs, otherErrs, checkerErrs);
    if (valueErrs == 0 && otherErrs == 0 && checkerErrs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testBridgeFtdi.f ====
+incdir+common
common/ftdiPkg.sv
common/dbioPkg.sv
ftdi/ftdiLink.sv
ftdi/sendFifo.sv
logic/commandEngine.sv
logic/dbioBuffer.sv
logic/testBridgeFtdi.sv
tb/testBridgeFtdi_checker.sv
tb/testBridgeFtdi_tb.sv

// ==== Bender.yml ====
package:
  name: testBridgeFtdi

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ftdiPkg.sv
      - common/dbioPkg.sv
      - ftdi/ftdiLink.sv
      - ftdi/sendFifo.sv
      - logic/commandEngine.sv
      - logic/dbioBuffer.sv
      - logic/testBridgeFtdi.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/testBridgeFtdi_checker.sv
      - tb/testBridgeFtdi_tb.sv
